//--- addr_stage.sv
`include "lsu_defines.svh"

module addr_stage import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   req_valid,
    input  word_t                  req_pc,
    input  op_t                    req_op,
    input  reg_idx_t               req_rj,
    input  reg_idx_t               req_rd,
    input  imm_t                   req_imm,
    output logic                   req_ready,
    output reg_idx_t               rf_raddr1,
    output reg_idx_t               rf_raddr2,
    input  word_t                  rf_rdata1,
    input  word_t                  rf_rdata2,
    input  logic                   ms_fwd_valid,
    input  reg_idx_t               ms_fwd_dest,
    input  word_t                  ms_fwd_data,
    input  logic                   ws_fwd_valid,
    input  reg_idx_t               ws_fwd_dest,
    input  word_t                  ws_fwd_data,
    input  logic                   ms_allowin,
    output logic                   es_to_ms_valid,
    output word_t                  es_pc,
    output op_t                    es_op,
    output reg_idx_t               es_dest,
    output word_t                  es_alu_result,
    output logic                   es_ex,
    output logic                   ram_en,
    output byte_en_t               ram_wen,
    output logic [`LSU_RAM_AW-1:0] ram_addr,
    output word_t                  ram_wdata
);

    logic     es_valid;
    logic     es_allowin;
    logic     es_go;
    reg_idx_t rj_r;
    reg_idx_t rd_r;
    imm_t     imm_r;
    word_t    base;
    word_t    src;
    word_t    sum;
    logic     is_load;
    logic     is_store;
    logic     is_half;
    logic     is_word;
    logic     misalign;
    byte_en_t st_be;
    word_t    st_data;

    // Youngest producer wins, the register file is the fallback.
    function automatic word_t fwd_sel(input reg_idx_t idx, input word_t rf_val);
        word_t val;
        if ((idx != '0) && ms_fwd_valid && (ms_fwd_dest == idx)) begin
            val = ms_fwd_data;
        end else if ((idx != '0) && ws_fwd_valid && (ws_fwd_dest == idx)) begin
            val = ws_fwd_data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    assign es_allowin     = !es_valid || ms_allowin;
    assign req_ready      = es_allowin;
    assign es_to_ms_valid = es_valid;
    assign es_go          = es_valid && ms_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= req_valid;
        end

        if (req_valid && es_allowin) begin
            es_pc <= req_pc;
            es_op <= req_op;
            rj_r  <= req_rj;
            rd_r  <= req_rd;
            imm_r <= req_imm;
        end
    end

    assign rf_raddr1 = rj_r;
    assign rf_raddr2 = rd_r;

    always_comb begin
        base = fwd_sel(rj_r, rf_rdata1);
        src  = fwd_sel(rd_r, rf_rdata2);
    end

    assign sum = base + word_t'(imm_r); // The cast sign-extends the immediate.

    assign is_store = (es_op == `OP_ST_B) || (es_op == `OP_ST_H) || (es_op == `OP_ST_W);
    assign is_load  = (es_op == `OP_LD_B) || (es_op == `OP_LD_H) || (es_op == `OP_LD_W)
                   || (es_op == `OP_LD_BU) || (es_op == `OP_LD_HU);
    assign is_half  = (es_op == `OP_LD_H) || (es_op == `OP_LD_HU) || (es_op == `OP_ST_H);
    assign is_word  = (es_op == `OP_LD_W) || (es_op == `OP_ST_W);
    assign misalign = (is_half && sum[0]) || (is_word && (sum[1:0] != 2'b00));

    always_comb begin
        case (es_op)
            `OP_ST_B: begin
                st_data = {4{src[7:0]}};
                st_be   = 4'b0001 << sum[1:0];
            end
            `OP_ST_H: begin
                st_data = {2{src[15:0]}};
                st_be   = sum[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                st_data = src;
                st_be   = 4'b1111;
            end
        endcase
    end

    assign es_dest       = is_store ? '0 : rd_r; // Stores never write a register.
    assign es_alu_result = sum;
    assign es_ex         = misalign;

    assign ram_en    = es_go && (is_load || is_store) && !misalign;
    assign ram_wen   = (es_go && is_store && !misalign) ? st_be : '0;
    assign ram_addr  = sum[`LSU_RAM_AW+1:2];
    assign ram_wdata = st_data;

endmodule

//--- data_ram.sv
`include "lsu_defines.svh"

module data_ram import lsu_pkg::*; (
    input  logic                   clk,
    input  logic                   en,
    input  byte_en_t               wen,
    input  logic [`LSU_RAM_AW-1:0] addr,
    input  word_t                  wdata,
    output word_t                  rdata
);

    word_t mem [0:(1 << `LSU_RAM_AW)-1];

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < $bits(byte_en_t); i++) begin
                if (wen[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
            rdata <= mem[addr]; // Read returns the old word on a store.
        end
    end

endmodule

//--- lsu_checker.sv
`include "lsu_defines.svh"

module lsu_checker import lsu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     retire_valid,
    input  logic     retire_ready,
    input  word_t    retire_pc,
    input  logic     retire_ex,
    input  logic     retire_we,
    input  reg_idx_t retire_dest,
    input  word_t    retire_data,
    output int       retire_count,
    output int       pass_count,
    output int       fail_count
);

    timeunit 1ns;
    timeprecision 100ps;

    string    name_q[$];
    word_t    pc_q[$];
    logic     ex_q[$];
    logic     we_q[$];
    reg_idx_t dest_q[$];
    word_t    res_q[$];
    int       idx       = 0;
    int       n_retired = 0;
    int       n_pass    = 0;
    int       n_fail    = 0;

    assign retire_count = n_retired;
    assign pass_count   = n_pass;
    assign fail_count   = n_fail;

    initial begin
        int          fd;
        string       line;
        string       name;
        int unsigned pc, op, rj, rd, imm, ex, res;
        logic        is_store;
        fd = $fopen("lsu_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "%s %h %h %h %h %h %h %h",
                            name, pc, op, rj, rd, imm, ex, res) == 8) begin
                    is_store = (op == `OP_ST_B) || (op == `OP_ST_H) || (op == `OP_ST_W);
                    name_q.push_back(name);
                    pc_q.push_back(word_t'(pc));
                    ex_q.push_back(ex != 0);
                    we_q.push_back((ex == 0) && !is_store && (rd != 0)); // Stores and faults write nothing.
                    dest_q.push_back(reg_idx_t'(rd));
                    res_q.push_back(word_t'(res));
                end
            end
            $fclose(fd);
        end
    end

    // The data of a faulting operation is undefined, so only its flags are compared.
    task automatic check_retire(input int i);
        if (retire_pc !== pc_q[i]) begin
            $display("FAIL %s pc expected %h actual %h", name_q[i], pc_q[i], retire_pc);
            n_fail++;
        end else if (retire_ex !== ex_q[i]) begin
            $display("FAIL %s exception expected %0b actual %0b", name_q[i], ex_q[i], retire_ex);
            n_fail++;
        end else if (retire_we !== we_q[i]) begin
            $display("FAIL %s register write expected %0b actual %0b",
                     name_q[i], we_q[i], retire_we);
            n_fail++;
        end else if (we_q[i] && (retire_dest !== dest_q[i])) begin
            $display("FAIL %s destination expected %0d actual %0d",
                     name_q[i], dest_q[i], retire_dest);
            n_fail++;
        end else if (!ex_q[i] && (retire_data !== res_q[i])) begin
            $display("FAIL %s result expected %h actual %h", name_q[i], res_q[i], retire_data);
            n_fail++;
        end else begin
            $display("PASS %s", name_q[i]);
            n_pass++;
        end
    endtask

    always @(posedge clk) begin
        if (!reset && retire_valid && retire_ready) begin
            n_retired++;
            if (idx >= name_q.size()) begin
                $display("ERROR: operation at pc %h retired with no expected result left",
                         retire_pc);
                n_fail++;
            end else begin
                check_retire(idx);
                idx++;
            end
        end
    end

endmodule

//--- lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Datapath and RAM geometry.
`define LSU_XLEN   32
`define LSU_RAM_AW 8
`define LSU_OP_W   4

// Operation codes carried from the request port down the pipeline.
`define OP_ADDI  4'd0
`define OP_LD_B  4'd1
`define OP_LD_H  4'd2
`define OP_LD_W  4'd3
`define OP_LD_BU 4'd4
`define OP_LD_HU 4'd5
`define OP_ST_B  4'd6
`define OP_ST_H  4'd7
`define OP_ST_W  4'd8

`endif

//--- lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

    // Data or address word.
    typedef logic [`LSU_XLEN-1:0] word_t;

    // Register number.
    typedef logic [4:0] reg_idx_t;

    typedef logic [`LSU_OP_W-1:0] op_t;

    // Immediate, sign-extended in the address stage.
    typedef logic signed [11:0] imm_t;

    // One enable per byte lane of a word.
    typedef logic [`LSU_XLEN/8-1:0] byte_en_t;

    // One-hot load kind, bit 0 up to bit 4 is b, h, w, bu, hu.
    typedef logic [4:0] load_sel_t;

endpackage

//--- lsu_properties.sv
module lsu_properties import lsu_pkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     retire_valid,
    input logic     retire_ready,
    input word_t    retire_pc,
    input logic     retire_ex,
    input logic     retire_we,
    input reg_idx_t retire_dest,
    input word_t    retire_data,
    input logic     es_to_ms_valid,
    input logic     es_ex,
    input byte_en_t ram_wen
);

    timeunit 1ns;
    timeprecision 100ps;

    int reset_fails = 0;
    int hold_fails  = 0;
    int wen_fails   = 0;
    int fail_count;

    assign fail_count = reset_fails + hold_fails + wen_fails;

    retire_idle_after_reset: assert property (@(posedge clk) reset |=> !retire_valid)
        else begin
            reset_fails++;
            $error("retire_valid is high in the cycle after reset");
        end

    // A stalled retire keeps every field of the retiring operation.
    retire_hold: assert property (@(posedge clk) disable iff (reset)
        (retire_valid && !retire_ready) |=> (retire_valid && $stable(retire_pc)
            && $stable(retire_ex) && $stable(retire_we) && $stable(retire_dest)
            && $stable(retire_data)))
        else begin
            hold_fails++;
            $error("retire outputs changed while retire_ready was low");
        end

    fault_no_write: assert property (@(posedge clk) disable iff (reset)
        (es_to_ms_valid && es_ex) |-> (ram_wen == '0))
        else begin
            wen_fails++;
            $error("RAM write enabled for an operation with an exception");
        end

endmodule

bind lsu_top lsu_properties u_props (
    .clk(clk), .reset(reset),
    .retire_valid(retire_valid), .retire_ready(retire_ready),
    .retire_pc(retire_pc), .retire_ex(retire_ex), .retire_we(retire_we),
    .retire_dest(retire_dest), .retire_data(retire_data),
    .es_to_ms_valid(es_to_ms_valid), .es_ex(es_ex), .ram_wen(ram_wen)
);

//--- lsu_stimulus.txt
# name pc op rj rd imm ex result, all numbers in hex
# op: 0 addi, 1 ld.b, 2 ld.h, 3 ld.w, 4 ld.bu, 5 ld.hu, 6 st.b, 7 st.h, 8 st.w
addi_r1_imm      00001000 0 00 01 100 0 00000100
addi_r2_fwd_ms   00001004 0 01 02 004 0 00000104
addi_r3_fwd_ws   00001008 0 01 03 ff8 0 000000f8
addi_r4_neg_imm  0000100c 0 00 04 876 0 fffff876
addi_r5_chain    00001010 0 04 05 7ff 0 00000075
addi_r6          00001014 0 00 06 012 0 00000012
addi_r7          00001018 0 00 07 085 0 00000085
addi_r9          0000101c 0 00 09 055 0 00000055
st_w_base        00001020 8 01 04 000 0 00000100
ld_w_after_st    00001024 3 01 08 000 0 fffff876
st_b_off2        00001028 6 01 06 002 0 00000102
st_b_off3        0000102c 6 01 07 003 0 00000103
ld_w_bytes       00001030 3 01 08 000 0 8512f876
ld_b_off0        00001034 1 01 0a 000 0 00000076
ld_b_off1        00001038 1 01 0a 001 0 fffffff8
ld_b_off2        0000103c 1 01 0a 002 0 00000012
ld_b_off3        00001040 1 01 0a 003 0 ffffff85
ld_bu_off0       00001044 4 01 0a 000 0 00000076
ld_bu_off1       00001048 4 01 0a 001 0 000000f8
ld_bu_off2       0000104c 4 01 0a 002 0 00000012
ld_bu_off3       00001050 4 01 0a 003 0 00000085
ld_h_off0        00001054 2 01 0a 000 0 fffff876
ld_h_off2        00001058 2 01 0a 002 0 ffff8512
ld_hu_off0       0000105c 5 01 0a 000 0 0000f876
ld_hu_off2       00001060 5 01 0a 002 0 00008512
st_w_w1          00001064 8 02 04 000 0 00000104
st_h_off2        00001068 7 02 06 002 0 00000106
st_h_off0        0000106c 7 02 07 000 0 00000104
ld_w_halves      00001070 3 02 08 000 0 00120085
ld_h_mis         00001074 2 01 09 001 1 00000000
ld_w_mis         00001078 3 01 09 002 1 00000000
st_w_mis         0000107c 8 02 06 001 1 00000000
st_h_mis         00001080 7 01 07 003 1 00000000
ld_hu_mis        00001084 5 01 09 005 1 00000000
ld_w_w1_kept     00001088 3 02 0a 000 0 00120085
ld_w_w0_kept     0000108c 3 01 0a 000 0 8512f876
addi_r9_kept     00001090 0 09 0b 001 0 00000056
ld_w_neg_off     00001094 3 02 0c ffc 0 8512f876
ld_w_r13         00001098 3 01 0d 000 0 8512f876
addi_ld_fwd      0000109c 0 0d 0e 001 0 8512f877
addi_r15         000010a0 0 00 0f 3a5 0 000003a5
st_w_fwd         000010a4 8 01 0f 008 0 00000108
ld_w_fwd_data    000010a8 3 01 10 008 0 000003a5

//--- lsu_top.sv
`include "lsu_defines.svh"

module lsu_top import lsu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     req_valid,
    input  word_t    req_pc,
    input  op_t      req_op,
    input  reg_idx_t req_rj,
    input  reg_idx_t req_rd,
    input  imm_t     req_imm,
    output logic     req_ready,
    input  logic     retire_ready,
    output logic     retire_valid,
    output word_t    retire_pc,
    output logic     retire_ex,
    output logic     retire_we,
    output reg_idx_t retire_dest,
    output word_t    retire_data
);

    reg_idx_t rf_raddr1;
    reg_idx_t rf_raddr2;
    word_t    rf_rdata1;
    word_t    rf_rdata2;
    logic     rf_we;
    reg_idx_t rf_waddr;
    word_t    rf_wdata;

    logic     ms_allowin;
    logic     ws_allowin;
    logic     es_to_ms_valid;
    logic     ms_to_ws_valid;

    word_t    es_pc;
    op_t      es_op;
    reg_idx_t es_dest;
    word_t    es_alu_result;
    logic     es_ex;

    word_t    ms_pc;
    logic     ms_ex;
    logic     ms_gr_we;
    reg_idx_t ms_dest;
    word_t    ms_final_result;

    logic     ms_fwd_valid;
    reg_idx_t ms_fwd_dest;
    word_t    ms_fwd_data;
    logic     ws_fwd_valid;
    reg_idx_t ws_fwd_dest;
    word_t    ws_fwd_data;

    logic                   ram_en;
    byte_en_t               ram_wen;
    logic [`LSU_RAM_AW-1:0] ram_addr;
    word_t                  ram_wdata;
    word_t                  ram_rdata;

    addr_stage u_addr_stage (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_pc(req_pc), .req_op(req_op),
        .req_rj(req_rj), .req_rd(req_rd), .req_imm(req_imm), .req_ready(req_ready),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .ms_fwd_valid(ms_fwd_valid), .ms_fwd_dest(ms_fwd_dest), .ms_fwd_data(ms_fwd_data),
        .ws_fwd_valid(ws_fwd_valid), .ws_fwd_dest(ws_fwd_dest), .ws_fwd_data(ws_fwd_data),
        .ms_allowin(ms_allowin), .es_to_ms_valid(es_to_ms_valid),
        .es_pc(es_pc), .es_op(es_op), .es_dest(es_dest),
        .es_alu_result(es_alu_result), .es_ex(es_ex),
        .ram_en(ram_en), .ram_wen(ram_wen), .ram_addr(ram_addr), .ram_wdata(ram_wdata)
    );

    mem_stage u_mem_stage (
        .clk(clk), .reset(reset),
        .es_to_ms_valid(es_to_ms_valid), .ms_allowin(ms_allowin),
        .es_pc(es_pc), .es_op(es_op), .es_dest(es_dest),
        .es_alu_result(es_alu_result), .es_ex(es_ex),
        .ws_allowin(ws_allowin), .ms_to_ws_valid(ms_to_ws_valid),
        .ms_pc(ms_pc), .ms_ex(ms_ex), .ms_gr_we(ms_gr_we), .ms_dest(ms_dest),
        .ms_final_result(ms_final_result),
        .ms_fwd_valid(ms_fwd_valid), .ms_fwd_dest(ms_fwd_dest), .ms_fwd_data(ms_fwd_data),
        .data_sram_rdata(ram_rdata)
    );

    wb_stage u_wb_stage (
        .clk(clk), .reset(reset),
        .ms_to_ws_valid(ms_to_ws_valid), .ws_allowin(ws_allowin),
        .ms_pc(ms_pc), .ms_ex(ms_ex), .ms_gr_we(ms_gr_we), .ms_dest(ms_dest),
        .ms_final_result(ms_final_result),
        .retire_ready(retire_ready), .retire_valid(retire_valid),
        .retire_pc(retire_pc), .retire_ex(retire_ex), .retire_we(retire_we),
        .retire_dest(retire_dest), .retire_data(retire_data),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .ws_fwd_valid(ws_fwd_valid), .ws_fwd_dest(ws_fwd_dest), .ws_fwd_data(ws_fwd_data)
    );

    reg_file u_reg_file (
        .clk(clk),
        .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

    data_ram u_data_ram (
        .clk(clk), .en(ram_en), .wen(ram_wen), .addr(ram_addr),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

endmodule

//--- mem_stage.sv
`include "lsu_defines.svh"

module mem_stage import lsu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     es_to_ms_valid,
    output logic     ms_allowin,
    input  word_t    es_pc,
    input  op_t      es_op,
    input  reg_idx_t es_dest,
    input  word_t    es_alu_result,
    input  logic     es_ex,
    input  logic     ws_allowin,
    output logic     ms_to_ws_valid,
    output word_t    ms_pc,
    output logic     ms_ex,
    output logic     ms_gr_we,
    output reg_idx_t ms_dest,
    output word_t    ms_final_result,
    output logic     ms_fwd_valid,
    output reg_idx_t ms_fwd_dest,
    output word_t    ms_fwd_data,
    input  word_t    data_sram_rdata
);

    logic      ms_valid;
    op_t       ms_op;
    word_t     ms_alu_result;
    logic      ex_r;
    load_sel_t load_sel;
    logic      res_from_mem;
    logic [3:0] vaddr_type;
    word_t     lb_data;
    word_t     lbu_data;
    word_t     lh_data;
    word_t     lhu_data;
    word_t     mem_result;

    assign ms_allowin     = !ms_valid || ws_allowin;
    assign ms_to_ws_valid = ms_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (ms_allowin) begin
            ms_valid <= es_to_ms_valid;
        end

        if (es_to_ms_valid && ms_allowin) begin
            ms_pc         <= es_pc;
            ms_op         <= es_op;
            ms_dest       <= es_dest;
            ms_alu_result <= es_alu_result;
            ex_r          <= es_ex;
        end
    end

    assign load_sel = {ms_op == `OP_LD_HU, ms_op == `OP_LD_BU, ms_op == `OP_LD_W,
                       ms_op == `OP_LD_H,  ms_op == `OP_LD_B};
    assign res_from_mem = |load_sel;

    assign vaddr_type = 4'b0001 << ms_alu_result[1:0]; // Byte lane as one-hot.

    assign lb_data  = {32{vaddr_type[0]}} & {{24{data_sram_rdata[ 7]}}, data_sram_rdata[ 7: 0]}
                    | {32{vaddr_type[1]}} & {{24{data_sram_rdata[15]}}, data_sram_rdata[15: 8]}
                    | {32{vaddr_type[2]}} & {{24{data_sram_rdata[23]}}, data_sram_rdata[23:16]}
                    | {32{vaddr_type[3]}} & {{24{data_sram_rdata[31]}}, data_sram_rdata[31:24]};

    assign lbu_data = {32{vaddr_type[0]}} & {24'b0, data_sram_rdata[ 7: 0]}
                    | {32{vaddr_type[1]}} & {24'b0, data_sram_rdata[15: 8]}
                    | {32{vaddr_type[2]}} & {24'b0, data_sram_rdata[23:16]}
                    | {32{vaddr_type[3]}} & {24'b0, data_sram_rdata[31:24]};

    assign lh_data  = ms_alu_result[1] ? {{16{data_sram_rdata[31]}}, data_sram_rdata[31:16]}
                                       : {{16{data_sram_rdata[15]}}, data_sram_rdata[15: 0]};

    assign lhu_data = ms_alu_result[1] ? {16'b0, data_sram_rdata[31:16]}
                                       : {16'b0, data_sram_rdata[15: 0]};

    assign mem_result = {32{load_sel[0]}} & lb_data
                      | {32{load_sel[1]}} & lh_data
                      | {32{load_sel[2]}} & data_sram_rdata
                      | {32{load_sel[3]}} & lbu_data
                      | {32{load_sel[4]}} & lhu_data;

    assign ms_final_result = res_from_mem ? mem_result : ms_alu_result;

    assign ms_ex    = ex_r && ms_valid;
    assign ms_gr_we = (ms_dest != '0) && !ex_r; // A faulting operation writes nothing.

    assign ms_fwd_valid = ms_valid && ms_gr_we;
    assign ms_fwd_dest  = ms_dest;
    assign ms_fwd_data  = ms_final_result;

endmodule

//--- reg_file.sv
module reg_file import lsu_pkg::*; (
    input  logic     clk,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    output word_t    rdata1,
    output word_t    rdata2,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata
);

    word_t regs [0:31];

    always_ff @(posedge clk) begin
        if (we && (waddr != '0)) begin
            regs[waddr] <= wdata; // Entry 0 is never written.
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- src.f
+incdir+.
lsu_pkg.sv
reg_file.sv
data_ram.sv
addr_stage.sv
mem_stage.sv
wb_stage.sv
lsu_top.sv
lsu_properties.sv
lsu_checker.sv
tb_lsu.sv

//--- tb_lsu.sv
`include "lsu_defines.svh"

module tb_lsu import lsu_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic     clk = 1'b0;
    logic     reset;
    logic     req_valid;
    word_t    req_pc;
    op_t      req_op;
    reg_idx_t req_rj;
    reg_idx_t req_rd;
    imm_t     req_imm;
    logic     req_ready;
    logic     retire_ready;
    logic     retire_valid;
    word_t    retire_pc;
    logic     retire_ex;
    logic     retire_we;
    reg_idx_t retire_dest;
    word_t    retire_data;

    word_t    pc_q[$];
    op_t      op_q[$];
    reg_idx_t rj_q[$];
    reg_idx_t rd_q[$];
    imm_t     imm_q[$];
    int       n_ops       = 0;
    int       load_errors = 0;
    bit       loaded      = 1'b0;
    bit       timed_out   = 1'b0;
    int       retire_count;
    int       pass_count;
    int       fail_count;

    always #20 clk = ~clk;

    lsu_top DUT (
        .clk(clk), .reset(reset),
        .req_valid(req_valid), .req_pc(req_pc), .req_op(req_op),
        .req_rj(req_rj), .req_rd(req_rd), .req_imm(req_imm), .req_ready(req_ready),
        .retire_ready(retire_ready), .retire_valid(retire_valid),
        .retire_pc(retire_pc), .retire_ex(retire_ex), .retire_we(retire_we),
        .retire_dest(retire_dest), .retire_data(retire_data)
    );

    lsu_checker u_checker (
        .clk(clk), .reset(reset),
        .retire_valid(retire_valid), .retire_ready(retire_ready),
        .retire_pc(retire_pc), .retire_ex(retire_ex), .retire_we(retire_we),
        .retire_dest(retire_dest), .retire_data(retire_data),
        .retire_count(retire_count), .pass_count(pass_count), .fail_count(fail_count)
    );

    task automatic read_stimulus();
        int          fd;
        string       line;
        string       name;
        int unsigned pc, op, rj, rd, imm, ex, res;
        fd = $fopen("lsu_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open lsu_stimulus.txt");
            load_errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%s %h %h %h %h %h %h %h",
                        name, pc, op, rj, rd, imm, ex, res) == 8) begin
                if (op > `OP_ST_W) begin
                    $display("ERROR: stimulus line %s has an unknown op code %0h", name, op);
                    load_errors++;
                end
                pc_q.push_back(word_t'(pc));
                op_q.push_back(op_t'(op));
                rj_q.push_back(reg_idx_t'(rj));
                rd_q.push_back(reg_idx_t'(rd));
                imm_q.push_back(imm_t'(imm));
            end
        end
        $fclose(fd);
    endtask

    // Back-pressure on the retire port, low on about one cycle in four.
    initial begin
        void'($urandom(10776));
        retire_ready = 1'b1;
        forever begin
            @(posedge clk);
            #2;
            retire_ready = (($urandom % 4) != 0);
        end
    end

    initial begin
        int limit;
        wait (loaded);
        limit = (20 * n_ops + 50) * 40; // Twenty clock periods per operation plus slack.
        #(limit);
        timed_out = 1'b1;
        $display("ERROR: watchdog expired after %0d ns with %0d of %0d operations retired",
                 limit, retire_count, n_ops);
    end

    initial begin
        int total_fail;
        reset     = 1'b1;
        req_valid = 1'b0;
        req_pc    = '0;
        req_op    = '0;
        req_rj    = '0;
        req_rd    = '0;
        req_imm   = '0;
        read_stimulus();
        n_ops  = pc_q.size();
        loaded = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;

        for (int i = 0; (i < n_ops) && !timed_out; i++) begin
            req_valid = 1'b1;
            req_pc    = pc_q[i];
            req_op    = op_q[i];
            req_rj    = rj_q[i];
            req_rd    = rd_q[i];
            req_imm   = imm_q[i];
            do begin
                @(posedge clk);
            end while (!req_ready && !timed_out); // Accepted at this edge.
            #2;
        end
        req_valid = 1'b0;

        while ((retire_count < n_ops) && !timed_out) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // A duplicated retire would show up here.

        total_fail = fail_count + load_errors + DUT.u_props.fail_count;
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d assertion failures",
                 n_ops, pass_count, fail_count + load_errors, DUT.u_props.fail_count);
        if (!timed_out && (total_fail == 0) && (pass_count == n_ops) && (n_ops > 0)) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- wb_stage.sv
module wb_stage import lsu_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     ms_to_ws_valid,
    output logic     ws_allowin,
    input  word_t    ms_pc,
    input  logic     ms_ex,
    input  logic     ms_gr_we,
    input  reg_idx_t ms_dest,
    input  word_t    ms_final_result,
    input  logic     retire_ready,
    output logic     retire_valid,
    output word_t    retire_pc,
    output logic     retire_ex,
    output logic     retire_we,
    output reg_idx_t retire_dest,
    output word_t    retire_data,
    output logic     rf_we,
    output reg_idx_t rf_waddr,
    output word_t    rf_wdata,
    output logic     ws_fwd_valid,
    output reg_idx_t ws_fwd_dest,
    output word_t    ws_fwd_data
);

    logic ws_valid;

    assign ws_allowin   = !ws_valid || retire_ready;
    assign retire_valid = ws_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ws_allowin) begin
            ws_valid <= ms_to_ws_valid;
        end

        if (ms_to_ws_valid && ws_allowin) begin
            retire_pc   <= ms_pc;
            retire_ex   <= ms_ex;
            retire_we   <= ms_gr_we;
            retire_dest <= ms_dest;
            retire_data <= ms_final_result;
        end
    end

    assign rf_we    = ws_valid && retire_ready && retire_we; // Write on the retire handshake.
    assign rf_waddr = retire_dest;
    assign rf_wdata = retire_data;

    // Held until retirement, so stalled consumers still see the value.
    assign ws_fwd_valid = ws_valid && retire_we;
    assign ws_fwd_dest  = retire_dest;
    assign ws_fwd_data  = retire_data;

endmodule
